// ==== all.f ====
+incdir+include
design/sniff_ctrl_pkg.sv
design/sniff_stats_pkg.sv
design/sniff_sequencer.sv
design/pulse_scorer.sv
design/pair_correlator.sv
design/data_path_sniffer.sv
sim/tb_data_path_sniffer.sv

// ==== design/data_path_sniffer.sv ====
`timescale 1ns/1ps

// -----------------------------------------------------------
// Data cable sniffer capture engine, top level
// -----------------------------------------------------------
module data_path_sniffer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             sniff_start,
    input  logic                             sniff_abort,
    input  sniff_ctrl_pkg::sniff_mode_t      sniff_mode,
    input  sniff_ctrl_pkg::duration_t        sniff_duration,
    input  logic                             data_se_rx,
    input  logic                             data_diff_rx,
    input  logic                             wire_a_raw,
    input  logic                             wire_b_raw,
    output logic                             sniff_busy,
    output logic                             sniff_done,
    output logic                             term_enable,
    output logic                             rx_mode_sel,
    output sniff_stats_pkg::edge_count_t     edge_count,
    output sniff_stats_pkg::runt_count_t     runt_count,
    output sniff_stats_pkg::opposite_count_t opposite_count,
    output logic                             is_differential
);

    import sniff_ctrl_pkg::*;
    import sniff_stats_pkg::*;

    // Sequencer to units
    logic            capture_en;
    logic            capture_clear;
    logic            corr_en;
    sniff_mode_t     capture_mode;

    // Live counts back to the sequencer
    edge_count_t     live_edges;
    runt_count_t     live_runts;
    opposite_count_t live_opposite;
    logic            live_is_diff;

    sniff_sequencer u_sequencer (
        .clk             (clk),
        .reset           (reset),
        .sniff_start     (sniff_start),
        .sniff_abort     (sniff_abort),
        .sniff_mode      (sniff_mode),
        .sniff_duration  (sniff_duration),
        .live_edges      (live_edges),
        .live_runts      (live_runts),
        .live_opposite   (live_opposite),
        .live_is_diff    (live_is_diff),
        .sniff_busy      (sniff_busy),
        .sniff_done      (sniff_done),
        .term_enable     (term_enable),
        .rx_mode_sel     (rx_mode_sel),
        .capture_en      (capture_en),
        .capture_clear   (capture_clear),
        .corr_en         (corr_en),
        .capture_mode    (capture_mode),
        .edge_count      (edge_count),
        .runt_count      (runt_count),
        .opposite_count  (opposite_count),
        .is_differential (is_differential)
    );

    pulse_scorer u_scorer (
        .clk           (clk),
        .reset         (reset),
        .capture_en    (capture_en),
        .capture_clear (capture_clear),
        .capture_mode  (capture_mode),
        .data_se_rx    (data_se_rx),
        .data_diff_rx  (data_diff_rx),
        .edge_count    (live_edges),
        .runt_count    (live_runts)
    );

    pair_correlator u_correlator (
        .clk             (clk),
        .reset           (reset),
        .corr_en         (corr_en),        // Gated with DIFF mode upstream
        .capture_clear   (capture_clear),
        .wire_a_raw      (wire_a_raw),
        .wire_b_raw      (wire_b_raw),
        .opposite_count  (live_opposite),
        .is_differential (live_is_diff)
    );

endmodule

// ==== design/pair_correlator.sv ====
`timescale 1ns/1ps

`include "sniff_consts.svh"

// -----------------------------------------------------------
// A/B wire opposite-state correlation
// -----------------------------------------------------------
module pair_correlator (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             corr_en,        // Capture window, DIFF only
    input  logic                             capture_clear,
    input  logic                             wire_a_raw,
    input  logic                             wire_b_raw,
    output sniff_stats_pkg::opposite_count_t opposite_count,
    output logic                             is_differential
);

    import sniff_stats_pkg::*;

    // Compare width, NUM fits below 2**SHIFT
    localparam int PROD_W = OPP_COUNT_W + `SNIFF_DIFF_SHIFT;

    opposite_count_t   sample_count;  // Enabled cycles
    logic [PROD_W-1:0] opp_scaled;
    logic [PROD_W-1:0] samp_scaled;

    // -----------------------------------------------------------
    // Sample and opposite counters
    // -----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset || capture_clear) begin
            sample_count   <= '0;
            opposite_count <= '0;
        end else if (corr_en) begin
            if (sample_count != '1) begin
                sample_count <= sample_count + 1'b1;
            end
            // A true pair sits in opposite states nearly all the time
            if ((wire_a_raw != wire_b_raw) && (opposite_count != '1)) begin
                opposite_count <= opposite_count + 1'b1;
            end
        end
    end

    // -----------------------------------------------------------
    // Ratio test, opposite / samples >= NUM / 2**SHIFT
    // -----------------------------------------------------------
    assign opp_scaled  = {opposite_count, {`SNIFF_DIFF_SHIFT{1'b0}}};
    assign samp_scaled = PROD_W'(sample_count) * PROD_W'(`SNIFF_DIFF_NUM);

    assign is_differential = (opp_scaled >= samp_scaled);  // From registered counts

endmodule

// ==== design/pulse_scorer.sv ====
`timescale 1ns/1ps

`include "sniff_consts.svh"

// -----------------------------------------------------------
// Edge and runt measurement on the selected receiver
// -----------------------------------------------------------
module pulse_scorer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         capture_en,     // High for every sampled cycle
    input  logic                         capture_clear,  // Clears before settling
    input  sniff_ctrl_pkg::sniff_mode_t  capture_mode,
    input  logic                         data_se_rx,     // SE receiver output
    input  logic                         data_diff_rx,   // Diff receiver output
    output sniff_stats_pkg::edge_count_t edge_count,
    output sniff_stats_pkg::runt_count_t runt_count
);

    import sniff_ctrl_pkg::*;
    import sniff_stats_pkg::*;

    localparam pulse_width_t RUNT_LIMIT = pulse_width_t'(`SNIFF_RUNT_WIDTH);

    logic         rx_sel;       // Receiver picked by mode
    logic         sample_q;     // Previous cycle's receiver value
    logic         edge_hit;
    logic         seen_edge;    // First edge of window already passed
    pulse_width_t pulse_width;

    // Receiver mux
    assign rx_sel = (capture_mode == MODE_DIFF) ? data_diff_rx : data_se_rx;

    // Sample history runs every cycle, so the first window cycle has a valid previous value
    always_ff @(posedge clk) begin
        sample_q <= rx_sel;
    end

    assign edge_hit = capture_en && (rx_sel != sample_q);  // Either polarity

    // -----------------------------------------------------------
    // Counters
    // -----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset || capture_clear) begin
            edge_count  <= '0;
            runt_count  <= '0;
            pulse_width <= '0;
            seen_edge   <= 1'b0;
        end else if (edge_hit) begin
            if (edge_count != '1) begin
                edge_count <= edge_count + 1'b1;  // Saturating
            end
            // Width before the first edge is not a whole pulse
            if (seen_edge && (pulse_width < RUNT_LIMIT) && (runt_count != '1)) begin
                runt_count <= runt_count + 1'b1;
            end
            seen_edge   <= 1'b1;
            pulse_width <= '0;  // New pulse starts
        end else if (capture_en) begin
            if (pulse_width != '1) begin
                pulse_width <= pulse_width + 1'b1;  // Saturating
            end
        end
    end

endmodule

// ==== design/sniff_ctrl_pkg.sv ====
// -----------------------------------------------------------
// Control types for the capture sequencer
// -----------------------------------------------------------
package sniff_ctrl_pkg;

    // Front-end mode, latched on the start strobe
    typedef enum logic {
        MODE_SE   = 1'b0,   // Single-ended receiver, no termination
        MODE_DIFF = 1'b1    // Differential receiver, termination on
    } sniff_mode_t;

    // Sequencer states
    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,  // Waiting for start
        ST_SETUP    = 3'd1,  // Front-end configure, unit clear
        ST_SETTLE   = 3'd2,  // Receiver settling
        ST_CAPTURE  = 3'd3,  // Sampling window
        ST_FINALIZE = 3'd4,  // Result latch
        ST_DONE     = 3'd5   // Done pulse issued from here
    } sniff_state_t;

    // Capture length in clock cycles
    typedef logic [23:0] duration_t;

endpackage

// ==== design/sniff_sequencer.sv ====
`timescale 1ns/1ps

`include "sniff_consts.svh"

// -----------------------------------------------------------
// Capture sequencer
// -----------------------------------------------------------
module sniff_sequencer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             sniff_start,     // One-cycle strobe
    input  logic                             sniff_abort,     // Level
    input  sniff_ctrl_pkg::sniff_mode_t      sniff_mode,      // Sampled with start
    input  sniff_ctrl_pkg::duration_t        sniff_duration,  // Sampled with start
    input  sniff_stats_pkg::edge_count_t     live_edges,
    input  sniff_stats_pkg::runt_count_t     live_runts,
    input  sniff_stats_pkg::opposite_count_t live_opposite,
    input  logic                             live_is_diff,
    output logic                             sniff_busy,
    output logic                             sniff_done,
    output logic                             term_enable,     // Termination on PHY
    output logic                             rx_mode_sel,     // 1 selects diff receiver
    output logic                             capture_en,
    output logic                             capture_clear,
    output logic                             corr_en,
    output sniff_ctrl_pkg::sniff_mode_t      capture_mode,
    output sniff_stats_pkg::edge_count_t     edge_count,
    output sniff_stats_pkg::runt_count_t     runt_count,
    output sniff_stats_pkg::opposite_count_t opposite_count,
    output logic                             is_differential
);

    import sniff_ctrl_pkg::*;

    // Settle counter just wide enough for the last count
    localparam int SETTLE_W = $clog2(`SNIFF_SETTLE_TIME + 1);
    localparam logic [SETTLE_W-1:0] SETTLE_LAST = SETTLE_W'(`SNIFF_SETTLE_TIME);

    sniff_state_t          state;
    duration_t             active_duration;  // Latched window length
    duration_t             capture_cnt;
    logic [SETTLE_W-1:0]   settle_cnt;

    // -----------------------------------------------------------
    // Unit controls, decoded straight from state
    // -----------------------------------------------------------
    assign capture_en    = (state == ST_CAPTURE);
    assign capture_clear = (state == ST_SETUP);
    assign corr_en       = capture_en && (capture_mode == MODE_DIFF);  // DIFF only

    // -----------------------------------------------------------
    // State machine and result registers
    // -----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= ST_IDLE;
            sniff_busy      <= 1'b0;
            sniff_done      <= 1'b0;
            term_enable     <= 1'b0;
            rx_mode_sel     <= 1'b0;
            capture_mode    <= MODE_SE;
            settle_cnt      <= '0;
            capture_cnt     <= '0;
            edge_count      <= '0;
            runt_count      <= '0;
            opposite_count  <= '0;
            is_differential <= 1'b0;
        end else begin
            sniff_done <= 1'b0;  // Pulse default

            case (state)
                ST_IDLE: begin
                    // Start outside idle never reaches here
                    if (sniff_start) begin
                        sniff_busy      <= 1'b1;
                        capture_mode    <= sniff_mode;
                        active_duration <= sniff_duration;
                        state           <= ST_SETUP;
                    end
                end

                ST_SETUP: begin
                    term_enable <= (capture_mode == MODE_DIFF);  // 100 ohm in DIFF
                    rx_mode_sel <= (capture_mode == MODE_DIFF);
                    settle_cnt  <= '0;
                    capture_cnt <= '0;
                    state       <= ST_SETTLE;
                end

                ST_SETTLE: begin
                    // Counts 0 to SETTLE_LAST, so one cycle over the settle time
                    if (sniff_abort) begin
                        state <= ST_DONE;  // Results left as they were
                    end else if (settle_cnt == SETTLE_LAST) begin
                        state <= ST_CAPTURE;
                    end else begin
                        settle_cnt <= settle_cnt + 1'b1;
                    end
                end

                ST_CAPTURE: begin
                    // Duration + 1 sampled cycles
                    if (sniff_abort || (capture_cnt == active_duration)) begin
                        state <= ST_FINALIZE;  // Abort keeps partial counts
                    end else begin
                        capture_cnt <= capture_cnt + 1'b1;
                    end
                end

                ST_FINALIZE: begin
                    edge_count <= live_edges;
                    runt_count <= live_runts;
                    if (capture_mode == MODE_DIFF) begin
                        opposite_count  <= live_opposite;
                        is_differential <= live_is_diff;
                    end else begin
                        // Correlation means nothing in SE mode
                        opposite_count  <= '0;
                        is_differential <= 1'b0;
                    end
                    state <= ST_DONE;
                end

                ST_DONE: begin
                    sniff_done <= 1'b1;  // Seen the cycle after DONE
                    sniff_busy <= 1'b0;  // Falls together with done
                    state      <= ST_IDLE;
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== design/sniff_stats_pkg.sv ====
// -----------------------------------------------------------
// Result and measurement types
// -----------------------------------------------------------
package sniff_stats_pkg;

    // Edges seen in the window
    // Saturates at all ones
    typedef logic [15:0] edge_count_t;

    // Pulses narrower than the runt limit
    // Saturates at all ones
    typedef logic [7:0] runt_count_t;

    // Running width of the current pulse in cycles
    // Saturates, so very long pulses read as the maximum
    typedef logic [15:0] pulse_width_t;

    // Opposite A/B cycles
    // Also sized for the sample count of the window
    typedef logic [23:0] opposite_count_t;

    // Handy widths
    localparam int EDGE_COUNT_W = $bits(edge_count_t);
    localparam int RUNT_COUNT_W = $bits(runt_count_t);
    localparam int OPP_COUNT_W  = $bits(opposite_count_t);

endpackage

// ==== include/sniff_consts.svh ====
`ifndef SNIFF_CONSTS_SVH
`define SNIFF_CONSTS_SVH

// -----------------------------------------------------------
// Capture engine constants
// -----------------------------------------------------------

// Front-end settling wait, in cycles
// Settle state runs one cycle longer than this
`define SNIFF_SETTLE_TIME 3000

// Pulse width limit
// Width below this on a non-first edge is a runt
`define SNIFF_RUNT_WIDTH 4

// Is-differential threshold as a ratio
// Opposite cycles must reach NUM / 2**SHIFT of all samples
`define SNIFF_DIFF_NUM 7
`define SNIFF_DIFF_SHIFT 3

`endif

// ==== sim/tb_data_path_sniffer.sv ====
`timescale 1ns/1ps

`include "sniff_consts.svh"

module tb_data_path_sniffer;

    import sniff_ctrl_pkg::*;
    import sniff_stats_pkg::*;

    localparam int PAIR_RANDOM   = 0;  // A and B independent
    localparam int PAIR_INVERSE  = 1;  // B driven as ~A
    localparam int NUM_RUNS      = 9;
    localparam int MAX_DUR       = 2000;
    localparam int CAP_FIRST     = `SNIFF_SETTLE_TIME + 3;  // First sampled edge after start edge
    localparam int BUSY_START_AT = 50;                      // Extra strobe while busy
    localparam int CYCLE_LIMIT   = NUM_RUNS * (`SNIFF_SETTLE_TIME + MAX_DUR + 10) + 1000;

    logic            clk;
    logic            reset;
    logic            sniff_start;
    logic            sniff_abort;
    sniff_mode_t     sniff_mode;
    duration_t       sniff_duration;
    logic            data_se_rx;
    logic            data_diff_rx;
    logic            wire_a_raw;
    logic            wire_b_raw;
    logic            sniff_busy;
    logic            sniff_done;
    logic            term_enable;
    logic            rx_mode_sel;
    edge_count_t     edge_count;
    runt_count_t     runt_count;
    opposite_count_t opposite_count;
    logic            is_differential;

    // Expected results kept across runs
    edge_count_t     exp_edges;
    runt_count_t     exp_runts;
    opposite_count_t exp_opp;
    logic            exp_diff;

    integer seed;
    int     mismatch_count;
    int     failure_count;
    int     cycle_count;
    duration_t abort_dur;

    data_path_sniffer DUT (.*);

    always #10 clk = ~clk;  // 20 ns period

    // -----------------------------------------------------------
    // Compare tasks per result type
    // -----------------------------------------------------------
    task automatic check_edges(input string name, input edge_count_t expected,
                               input edge_count_t actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_runts(input string name, input runt_count_t expected,
                               input runt_count_t actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_opposite(input string name, input opposite_count_t expected,
                                  input opposite_count_t actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t: %s", $time, what);
        failure_count++;
    endtask

    task automatic check_results();
        check_edges("edge_count", exp_edges, edge_count);
        check_runts("runt_count", exp_runts, runt_count);
        check_opposite("opposite_count", exp_opp, opposite_count);
        check_bit("is_differential", exp_diff, is_differential);
    endtask

    // -----------------------------------------------------------
    // Stimulus
    // -----------------------------------------------------------
    function automatic duration_t rand_duration();
        return duration_t'(16 + ($unsigned($random(seed)) % (MAX_DUR - 15)));  // 16 to 2000
    endfunction

    // Receivers mostly hold and toggle one cycle in eight
    task automatic drive_data(input int pair_kind);
        logic [31:0] r;
        r = $random(seed);
        if (r[2:0] == 3'd0) data_se_rx <= ~data_se_rx;
        if (r[5:3] == 3'd0) data_diff_rx <= ~data_diff_rx;
        wire_a_raw <= r[8];
        wire_b_raw <= (pair_kind == PAIR_INVERSE) ? ~r[8] : r[9];
    endtask

    // One start-to-done run with abort at abort_edge when nonzero
    task automatic run_capture(input sniff_mode_t mode, input duration_t dur,
                               input int pair_kind, input int abort_edge);
        int              k;
        int              cap_last;
        int              done_edge;
        logic            settle_abort;
        logic            finished;
        logic            rx_now;
        logic            prev_rx;
        logic            seen_edge;
        pulse_width_t    width;
        edge_count_t     m_edges;
        runt_count_t     m_runts;
        opposite_count_t m_opp;
        opposite_count_t m_samp;

        settle_abort = (abort_edge != 0) && (abort_edge < CAP_FIRST);
        cap_last     = (abort_edge != 0) ? abort_edge : CAP_FIRST + int'(dur);
        done_edge    = settle_abort ? abort_edge + 2 : cap_last + 3;
        k         = 0;
        finished  = 1'b0;
        prev_rx   = 1'b0;
        seen_edge = 1'b0;
        width     = '0;
        m_edges   = '0;
        m_runts   = '0;
        m_opp     = '0;
        m_samp    = '0;

        @(posedge clk);
        sniff_start    <= 1'b1;
        sniff_mode     <= mode;
        sniff_duration <= dur;
        drive_data(pair_kind);

        while (!finished) begin
            @(posedge clk);
            rx_now = (mode == MODE_DIFF) ? data_diff_rx : data_se_rx;
            if (!settle_abort && (k >= CAP_FIRST) && (k <= cap_last)) begin  // Sampled cycle
                if (rx_now != prev_rx) begin
                    if (m_edges != '1) m_edges++;
                    if (seen_edge && (width < `SNIFF_RUNT_WIDTH) && (m_runts != '1)) m_runts++;
                    seen_edge = 1'b1;
                    width     = '0;
                end else if (width != '1) begin
                    width++;
                end
                if (mode == MODE_DIFF) begin
                    m_samp++;
                    if (wire_a_raw != wire_b_raw) m_opp++;
                end
            end
            prev_rx = rx_now;

            if (k == done_edge) begin
                if (sniff_done !== 1'b1) begin
                    report_failure("done pulse missing at the expected cycle");
                end
                if (sniff_busy !== 1'b0) begin
                    report_failure("busy still high with the done pulse");
                end
                if (!settle_abort) begin  // Settle abort leaves old results
                    exp_edges = m_edges;
                    exp_runts = m_runts;
                    exp_opp   = (mode == MODE_DIFF) ? m_opp : '0;
                    exp_diff  = (mode == MODE_DIFF) &&
                                (longint'(m_opp) * (2 ** `SNIFF_DIFF_SHIFT) >=
                                 longint'(m_samp) * `SNIFF_DIFF_NUM);
                end
                check_results();
                finished = 1'b1;
            end else if (k >= 1) begin
                if (sniff_done !== 1'b0) begin
                    report_failure("done pulse came before the end of the run");
                end
                if (sniff_busy !== 1'b1) begin
                    report_failure("busy went low in the middle of a run");
                end
            end
            if (k >= 2) begin  // Front end set at end of setup
                check_bit("term_enable", mode == MODE_DIFF, term_enable);
                check_bit("rx_mode_sel", mode == MODE_DIFF, rx_mode_sel);
            end

            sniff_start <= (k == BUSY_START_AT);
            if (k == BUSY_START_AT) begin
                sniff_mode     <= (mode == MODE_SE) ? MODE_DIFF : MODE_SE;  // Other request
                sniff_duration <= 24'd5;
            end
            sniff_abort <= (abort_edge != 0) && (k + 1 == abort_edge);  // Seen at abort_edge
            drive_data(pair_kind);
            k++;
        end
    endtask

    // -----------------------------------------------------------
    // Watchdog
    // -----------------------------------------------------------
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Error: run exceeded %0d cycles without finishing", CYCLE_LIMIT);
        $display("Test failed");
        $finish;
    end

    // -----------------------------------------------------------
    // Main sequence
    // -----------------------------------------------------------
    initial begin
        seed           = 32'h1fbe52f8;
        mismatch_count = 0;
        failure_count  = 0;
        clk            = 1'b0;
        reset          = 1'b1;
        sniff_start    = 1'b0;
        sniff_abort    = 1'b0;
        sniff_mode     = MODE_SE;
        sniff_duration = '0;
        data_se_rx     = 1'b0;
        data_diff_rx   = 1'b0;
        wire_a_raw     = 1'b0;
        wire_b_raw     = 1'b1;
        exp_edges      = '0;
        exp_runts      = '0;
        exp_opp        = '0;
        exp_diff       = 1'b0;

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_bit("sniff_busy", 1'b0, sniff_busy);  // All low out of reset
        check_bit("sniff_done", 1'b0, sniff_done);
        check_bit("term_enable", 1'b0, term_enable);
        check_bit("rx_mode_sel", 1'b0, rx_mode_sel);
        check_results();

        repeat (3) run_capture(MODE_SE, rand_duration(), PAIR_RANDOM, 0);
        repeat (2) run_capture(MODE_DIFF, rand_duration(), PAIR_INVERSE, 0);
        repeat (2) run_capture(MODE_DIFF, rand_duration(), PAIR_RANDOM, 0);
        run_capture(MODE_DIFF, rand_duration(), PAIR_INVERSE, 1000);  // Abort in settle
        abort_dur = rand_duration();
        run_capture(MODE_SE, abort_dur, PAIR_RANDOM, CAP_FIRST + int'(abort_dur) / 2);

        $display("Checks done: %0d mismatches, %0d other errors", mismatch_count, failure_count);
        if ((mismatch_count == 0) && (failure_count == 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
